//--- verilog/mhq_defs.svh
// MHQ widths and queue geometry shared by every block of the miss handling queue
`ifndef MHQ_DEFS_SVH
`define MHQ_DEFS_SVH

// Store data word and byte address
`define MHQ_DATA_WIDTH 32
`define MHQ_ADDR_WIDTH 32

// Number of outstanding line misses
`define MHQ_DEPTH 4

// Bytes per data cache line
`define MHQ_LINE_SIZE 16

// Derived widths
`define MHQ_IDX_WIDTH ($clog2(`MHQ_DEPTH))
`define MHQ_OFFSET_WIDTH ($clog2(`MHQ_LINE_SIZE))
`define MHQ_LINE_WIDTH (`MHQ_LINE_SIZE * 8)

`endif

//--- verilog/mhq_pkg.sv
// MHQ types: LSU operation codes and the two views of a lookup address
`default_nettype none

`include "mhq_defs.svh"

package mhq_pkg;

    // Operation presented by the load/store unit with each lookup
    typedef enum logic [2:0] {
        MHQ_OP_LB   = 3'd0,
        MHQ_OP_LH   = 3'd1,
        MHQ_OP_LW   = 3'd2,
        MHQ_OP_SB   = 3'd3,
        MHQ_OP_SH   = 3'd4,
        MHQ_OP_SW   = 3'd5,
        MHQ_OP_FILL = 3'd6
    } mhq_op_e;

    // Byte address split into cache line address and byte offset in the line
    typedef struct packed {
        logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] line;
        logic [`MHQ_OFFSET_WIDTH-1:0]               offset;
    } mhq_addr_s;

    // The same word seen either raw or as line plus offset
    typedef union packed {
        logic [`MHQ_ADDR_WIDTH-1:0] word;
        mhq_addr_s                  fields;
    } mhq_addr_u;

endpackage

`default_nettype wire

//--- verilog/mhq_update_if.sv
// MHQ update bus from the lookup stage to the entry array
`timescale 1ns/1ns
`default_nettype none

`include "mhq_defs.svh"

interface mhq_update_if;

    // One-hot entry to update, all zero when nothing is written
    logic [`MHQ_DEPTH-1:0]                      select;
    logic                                       we;
    // Store data and byte enables already placed at their line offset
    logic [`MHQ_LINE_WIDTH-1:0]                 wr_data;
    logic [`MHQ_LINE_SIZE-1:0]                  byte_select;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] addr;

    modport src (output select, we, wr_data, byte_select, addr);
    modport dst (input select, we, wr_data, byte_select, addr);

endinterface

`default_nettype wire

//--- verilog/mhq_lookup.sv
// MHQ lookup stage: entry match, allocation, retry and replay, store byte placement
`timescale 1ns/1ns
`default_nettype none

`include "mhq_defs.svh"

module mhq_lookup
    import mhq_pkg::*;
(
    input  logic                                       clk,
    input  logic                                       i_rst_n,

    // State of the entry array
    input  logic                                       i_full,
    input  logic [`MHQ_DEPTH-1:0]                      i_hit_select,
    input  logic [`MHQ_DEPTH-1:0]                      i_alloc_select,
    input  logic [`MHQ_DEPTH-1:0]                      i_bypass_select,
    input  logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] i_bypass_addr,

    // Lookup from the LSU
    input  logic                                       i_lookup_valid,
    input  logic                                       i_lookup_we,
    input  logic                                       i_lookup_dc_hit,
    input  mhq_addr_u                                  i_lookup_addr,
    input  mhq_op_e                                    i_lookup_op,
    input  logic [`MHQ_DATA_WIDTH-1:0]                 i_lookup_data,

    // Fill progress used to detect conflicts
    input  logic                                       i_ccu_done,
    input  logic                                       i_completing,
    input  logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] i_completing_addr,
    input  logic                                       i_filling,
    input  logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] i_filling_addr,

    output logic [`MHQ_IDX_WIDTH-1:0]                  o_lookup_tag,
    output logic                                       o_lookup_retry,
    output logic                                       o_lookup_replay,
    output logic                                       o_lookup_allocating,

    mhq_update_if.src                                  upd
);

    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] lookup_line;
    logic [`MHQ_OFFSET_WIDTH-1:0]               lookup_offset;
    logic                                       entry_hit;
    logic                                       bypass_hit;
    logic                                       lookup_hit;
    logic [`MHQ_DEPTH-1:0]                      lookup_select;
    logic [`MHQ_IDX_WIDTH-1:0]                  lookup_entry;
    logic                                       retry;
    logic                                       replay;
    logic                                       update_en;
    logic [`MHQ_LINE_SIZE-1:0]                  byte_select;
    logic [`MHQ_LINE_WIDTH-1:0]                 wr_data;

    assign lookup_line   = i_lookup_addr.fields.line;
    assign lookup_offset = i_lookup_addr.fields.offset;

    // The entry being written this cycle is not yet visible in the array, so its
    // address is compared here as well
    assign entry_hit  = |i_hit_select;
    assign bypass_hit = (|i_bypass_select) && (i_bypass_addr == lookup_line);
    assign lookup_hit = i_lookup_valid & (entry_hit | bypass_hit);

    // Priority: bypassed entry, then a queued entry, then the tail for a new miss
    always_comb begin
        if (bypass_hit) begin
            lookup_select = i_bypass_select;
        end else if (entry_hit) begin
            lookup_select = i_hit_select;
        end else begin
            lookup_select = i_alloc_select;
        end
    end

    // One-hot to entry number
    always_comb begin
        lookup_entry = '0;
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (lookup_select[i]) begin
                lookup_entry = lookup_entry | i[`MHQ_IDX_WIDTH-1:0];
            end
        end
    end

    // A miss cannot be taken while every entry is busy
    assign retry = i_lookup_valid & i_full & ~lookup_hit;

    // The head line is about to leave the queue: in the CCU done cycle, while it is
    // merged, and while the finished fill goes out to the LSU
    assign replay = i_lookup_valid &
                    ((((i_ccu_done | i_completing) && (i_completing_addr == lookup_line))) |
                     (i_filling && (i_filling_addr == lookup_line)));

    assign update_en = i_lookup_valid & ~i_lookup_dc_hit & (i_lookup_op != MHQ_OP_FILL) &
                       ~retry & ~replay;

    // Combinational so the LSU sees it in the lookup cycle
    assign o_lookup_allocating = update_en & ~lookup_hit;

    // Store bytes at the line offset, anything past the end of the line drops off
    always_comb begin
        case (i_lookup_op)
            MHQ_OP_SB: byte_select = `MHQ_LINE_SIZE'(4'h1);
            MHQ_OP_SH: byte_select = `MHQ_LINE_SIZE'(4'h3);
            MHQ_OP_SW: byte_select = `MHQ_LINE_SIZE'(4'hf);
            default:   byte_select = '0;
        endcase
        byte_select = byte_select << lookup_offset;
    end

    // Data moves by the same number of bytes
    assign wr_data = {{(`MHQ_LINE_WIDTH - `MHQ_DATA_WIDTH){1'b0}}, i_lookup_data} <<
                     {lookup_offset, 3'b000};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_lookup_retry  <= 1'b0;
            o_lookup_replay <= 1'b0;
            upd.select      <= '0;
        end else begin
            o_lookup_retry  <= retry;
            o_lookup_replay <= replay;
            upd.select      <= update_en ? lookup_select : '0;
        end
    end

    // Payload of the update, only meaningful with a select bit set
    always_ff @(posedge clk) begin
        o_lookup_tag    <= lookup_entry;
        upd.we          <= i_lookup_we;
        upd.wr_data     <= wr_data;
        upd.byte_select <= byte_select;
        upd.addr        <= lookup_line;
    end

endmodule

`default_nettype wire

//--- verilog/mhq_entries.sv
// MHQ entry array: circular queue of missed lines with merged store bytes
`timescale 1ns/1ns
`default_nettype none

`include "mhq_defs.svh"

module mhq_entries (
    input  logic                                       clk,
    input  logic                                       i_rst_n,

    // Lookup compare and allocation
    input  logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] i_lookup_line,
    output logic [`MHQ_DEPTH-1:0]                      o_hit_select,
    output logic [`MHQ_DEPTH-1:0]                      o_alloc_select,
    output logic                                       o_full,
    output logic [`MHQ_DEPTH-1:0]                      o_bypass_select,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_bypass_addr,

    mhq_update_if.dst                                  upd,

    // Head entry towards the fill block
    input  logic                                       i_dequeue,
    output logic                                       o_head_valid,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_head_addr,
    output logic [`MHQ_LINE_WIDTH-1:0]                 o_head_data,
    output logic [`MHQ_LINE_SIZE-1:0]                  o_head_mask
);

    logic [`MHQ_DEPTH-1:0]                      valid;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] line_addr [`MHQ_DEPTH];
    logic [`MHQ_LINE_WIDTH-1:0]                 line_data [`MHQ_DEPTH];
    logic [`MHQ_LINE_SIZE-1:0]                  line_mask [`MHQ_DEPTH];

    logic [`MHQ_IDX_WIDTH-1:0]                  head;
    logic [`MHQ_IDX_WIDTH-1:0]                  tail;
    logic [`MHQ_IDX_WIDTH-1:0]                  tail_next;
    logic [`MHQ_IDX_WIDTH:0]                    count;
    logic [`MHQ_IDX_WIDTH:0]                    count_next;
    logic [`MHQ_DEPTH-1:0]                      tail_select;
    logic                                       enqueue;

    // Valid entries holding the looked-up line
    always_comb begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            o_hit_select[i] = valid[i] && (line_addr[i] == i_lookup_line);
        end
    end

    // An update that lands on the free tail is a new allocation
    assign tail_select = `MHQ_DEPTH'(1) << tail;
    assign enqueue     = |(upd.select & tail_select & ~valid);
    assign tail_next   = tail + `MHQ_IDX_WIDTH'(enqueue);

    always_comb begin
        count_next = count;
        if (enqueue) begin
            count_next = count_next + 1'b1;
        end
        if (i_dequeue) begin
            count_next = count_next - 1'b1;
        end
    end

    // Allocation and fullness already account for the update in flight, so a
    // miss right behind another miss gets the next entry
    assign o_alloc_select = `MHQ_DEPTH'(1) << tail_next;
    assign o_full         = (count_next == `MHQ_DEPTH);

    // The entry under update and its line, for the lookup stage compare
    assign o_bypass_select = upd.select;
    assign o_bypass_addr   = upd.addr;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail_next;
            count <= count_next;
            if (i_dequeue) begin
                head <= head + 1'b1;
            end
            for (int i = 0; i < `MHQ_DEPTH; i++) begin
                if (upd.select[i] && !valid[i]) begin
                    valid[i] <= 1'b1;
                end else if (i_dequeue && (head == i[`MHQ_IDX_WIDTH-1:0])) begin
                    valid[i] <= 1'b0;
                end
            end
        end
    end

    // Line address is taken on allocation, store bytes merge on every write
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (upd.select[i]) begin
                if (!valid[i]) begin
                    line_addr[i] <= upd.addr;
                    line_mask[i] <= upd.we ? upd.byte_select : '0;
                end else if (upd.we) begin
                    line_mask[i] <= line_mask[i] | upd.byte_select;
                end
                for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
                    if (upd.we && upd.byte_select[b]) begin
                        line_data[i][b*8 +: 8] <= upd.wr_data[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign o_head_valid = valid[head];
    assign o_head_addr  = line_addr[head];
    assign o_head_data  = line_data[head];
    assign o_head_mask  = line_mask[head];

endmodule

`default_nettype wire

//--- verilog/mhq_fill.sv
// MHQ fill: CCU request for the head line, store merge and fill launch to the LSU
`timescale 1ns/1ns
`default_nettype none

`include "mhq_defs.svh"

module mhq_fill (
    input  logic                                       clk,
    input  logic                                       i_rst_n,

    // Head entry of the queue
    input  logic                                       i_head_valid,
    input  logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] i_head_addr,
    input  logic [`MHQ_LINE_WIDTH-1:0]                 i_head_data,
    input  logic [`MHQ_LINE_SIZE-1:0]                  i_head_mask,

    // CCU request and answer
    input  logic                                       i_ccu_done,
    input  logic [`MHQ_LINE_WIDTH-1:0]                 i_ccu_data,
    output logic                                       o_ccu_req,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_ccu_addr,

    output logic                                       o_dequeue,

    // Fill progress for the lookup stage conflict check
    output logic                                       o_ccu_done,
    output logic                                       o_completing,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_completing_addr,
    output logic                                       o_filling,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_filling_addr,

    // Finished line to the LSU
    output logic                                       o_fill_valid,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_fill_addr,
    output logic [`MHQ_LINE_WIDTH-1:0]                 o_fill_data
);

    logic                       answered;
    logic                       completing;
    logic [`MHQ_LINE_WIDTH-1:0] ccu_data_q;
    logic [`MHQ_LINE_WIDTH-1:0] merged;

    // Held until the CCU answers, then quiet until the next head shows up
    assign o_ccu_req  = i_head_valid & ~answered;
    assign o_ccu_addr = i_head_addr;

    // Stores queued in the entry win over the memory line
    always_comb begin
        for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
            merged[b*8 +: 8] = i_head_mask[b] ? i_head_data[b*8 +: 8] : ccu_data_q[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            answered     <= 1'b0;
            completing   <= 1'b0;
            o_fill_valid <= 1'b0;
        end else begin
            // Set in the done cycle, cleared as the head leaves
            if (completing) begin
                answered <= 1'b0;
            end else if (i_ccu_done) begin
                answered <= 1'b1;
            end
            completing   <= i_ccu_done;
            o_fill_valid <= completing;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ccu_done) begin
            ccu_data_q <= i_ccu_data;
        end
        if (completing) begin
            o_fill_addr <= i_head_addr;
            o_fill_data <= merged;
        end
    end

    // The head entry is freed in the merge cycle
    assign o_dequeue = completing;

    // Until the dequeue the head is the line being filled
    assign o_ccu_done        = i_ccu_done;
    assign o_completing      = completing;
    assign o_completing_addr = i_head_addr;
    assign o_filling         = o_fill_valid;
    assign o_filling_addr    = o_fill_addr;

endmodule

`default_nettype wire

//--- verilog/mhq_top.sv
// MHQ top: lookup stage, entry array and fill block of the data cache miss queue
`timescale 1ns/1ns
`default_nettype none

`include "mhq_defs.svh"

module mhq_top
    import mhq_pkg::*;
(
    input  logic                                       clk,
    input  logic                                       i_rst_n,

    // Lookup from the LSU
    input  logic                                       i_lookup_valid,
    input  logic                                       i_lookup_we,
    input  logic                                       i_lookup_dc_hit,
    input  logic [`MHQ_ADDR_WIDTH-1:0]                 i_lookup_addr,
    input  logic [2:0]                                 i_lookup_op,
    input  logic [`MHQ_DATA_WIDTH-1:0]                 i_lookup_data,
    output logic [`MHQ_IDX_WIDTH-1:0]                  o_lookup_tag,
    output logic                                       o_lookup_retry,
    output logic                                       o_lookup_replay,
    output logic                                       o_lookup_allocating,
    output logic                                       o_mhq_full,

    // CCU
    output logic                                       o_ccu_req,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_ccu_addr,
    input  logic                                       i_ccu_done,
    input  logic [`MHQ_LINE_WIDTH-1:0]                 i_ccu_data,

    // Fill to the LSU
    output logic                                       o_fill_valid,
    output logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_fill_addr,
    output logic [`MHQ_LINE_WIDTH-1:0]                 o_fill_data
);

    mhq_addr_u                                  lookup_addr;
    mhq_op_e                                    lookup_op;
    logic [`MHQ_DEPTH-1:0]                      hit_select;
    logic [`MHQ_DEPTH-1:0]                      alloc_select;
    logic [`MHQ_DEPTH-1:0]                      bypass_select;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] bypass_addr;
    logic                                       head_valid;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] head_addr;
    logic [`MHQ_LINE_WIDTH-1:0]                 head_data;
    logic [`MHQ_LINE_SIZE-1:0]                  head_mask;
    logic                                       dequeue;
    logic                                       ccu_done;
    logic                                       completing;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] completing_addr;
    logic                                       filling;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] filling_addr;

    // Raw address word in, line and offset fields are read inside
    assign lookup_addr.word = i_lookup_addr;
    assign lookup_op        = mhq_op_e'(i_lookup_op);

    mhq_update_if upd ();

    mhq_lookup u_lookup (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_full             (o_mhq_full),
        .i_hit_select       (hit_select),
        .i_alloc_select     (alloc_select),
        .i_bypass_select    (bypass_select),
        .i_bypass_addr      (bypass_addr),
        .i_lookup_valid     (i_lookup_valid),
        .i_lookup_we        (i_lookup_we),
        .i_lookup_dc_hit    (i_lookup_dc_hit),
        .i_lookup_addr      (lookup_addr),
        .i_lookup_op        (lookup_op),
        .i_lookup_data      (i_lookup_data),
        .i_ccu_done         (ccu_done),
        .i_completing       (completing),
        .i_completing_addr  (completing_addr),
        .i_filling          (filling),
        .i_filling_addr     (filling_addr),
        .o_lookup_tag       (o_lookup_tag),
        .o_lookup_retry     (o_lookup_retry),
        .o_lookup_replay    (o_lookup_replay),
        .o_lookup_allocating(o_lookup_allocating),
        .upd                (upd.src)
    );

    mhq_entries u_entries (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_lookup_line  (lookup_addr.fields.line),
        .o_hit_select   (hit_select),
        .o_alloc_select (alloc_select),
        .o_full         (o_mhq_full),
        .o_bypass_select(bypass_select),
        .o_bypass_addr  (bypass_addr),
        .upd            (upd.dst),
        .i_dequeue      (dequeue),
        .o_head_valid   (head_valid),
        .o_head_addr    (head_addr),
        .o_head_data    (head_data),
        .o_head_mask    (head_mask)
    );

    mhq_fill u_fill (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_head_valid     (head_valid),
        .i_head_addr      (head_addr),
        .i_head_data      (head_data),
        .i_head_mask      (head_mask),
        .i_ccu_done       (i_ccu_done),
        .i_ccu_data       (i_ccu_data),
        .o_ccu_req        (o_ccu_req),
        .o_ccu_addr       (o_ccu_addr),
        .o_dequeue        (dequeue),
        .o_ccu_done       (ccu_done),
        .o_completing     (completing),
        .o_completing_addr(completing_addr),
        .o_filling        (filling),
        .o_filling_addr   (filling_addr),
        .o_fill_valid     (o_fill_valid),
        .o_fill_addr      (o_fill_addr),
        .o_fill_data      (o_fill_data)
    );

endmodule

`default_nettype wire

//--- test/mhq_tb.sv
// MHQ testbench that plays the LSU and the CCU and checks the DUT against a queue model
`timescale 1ns/1ns
`default_nettype none

`include "mhq_defs.svh"

module mhq_tb
    import mhq_pkg::*;
();

    logic                                       clk;
    logic                                       i_rst_n;
    logic                                       i_lookup_valid;
    logic                                       i_lookup_we;
    logic                                       i_lookup_dc_hit;
    logic [`MHQ_ADDR_WIDTH-1:0]                 i_lookup_addr;
    logic [2:0]                                 i_lookup_op;
    logic [`MHQ_DATA_WIDTH-1:0]                 i_lookup_data;
    logic [`MHQ_IDX_WIDTH-1:0]                  o_lookup_tag;
    logic                                       o_lookup_retry;
    logic                                       o_lookup_replay;
    logic                                       o_lookup_allocating;
    logic                                       o_mhq_full;
    logic                                       o_ccu_req;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_ccu_addr;
    logic                                       i_ccu_done;
    logic [`MHQ_LINE_WIDTH-1:0]                 i_ccu_data;
    logic                                       o_fill_valid;
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] o_fill_addr;
    logic [`MHQ_LINE_WIDTH-1:0]                 o_fill_data;

    // Model of the queue indexed by entry number like the DUT
    logic                                       mv [`MHQ_DEPTH];
    logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] ml [`MHQ_DEPTH];
    logic [`MHQ_LINE_WIDTH-1:0]                 md [`MHQ_DEPTH];
    logic [`MHQ_LINE_SIZE-1:0]                  mm [`MHQ_DEPTH];
    int mhead, mtail, mcount, allocs;

    // Fill pulses and CCU requests seen on the DUT outputs
    int   fills, reqs;
    logic req_q;

    // Registered lookup results still to be checked in the next cycle
    logic pend, pupd, pretry, preplay, pfull;
    int   ptag;

    logic [15:0] lfsr;
    int errors, checks, tests, failed, start_err;

    mhq_top i_mhq_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Nothing in this run needs more than a few hundred cycles
    initial begin
        #200000;
        $display("timeout: the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // Each new CCU request starts with a rising o_ccu_req
    always @(negedge clk) begin
        if (!i_rst_n) begin
            req_q = 1'b0;
        end else begin
            if (o_fill_valid) begin
                fills++;
            end
            if (o_ccu_req && !req_q) begin
                reqs++;
            end
            req_q = o_ccu_req;
        end
    end

    // Fibonacci LFSR with taps at bits 16 14 13 and 11 that steps once per bit taken
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    task automatic chk(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Registered outputs of the previous lookup are stable at this edge
    task automatic tick();
        @(negedge clk);
        if (pend) begin
            chk("o_lookup_retry", o_lookup_retry, pretry);
            chk("o_lookup_replay", o_lookup_replay, preplay);
            chk("o_mhq_full", o_mhq_full, pfull);
            if (pupd) begin
                chk("o_lookup_tag", o_lookup_tag, ptag);
            end
            pend = 1'b0;
        end
    endtask

    task automatic drive_idle();
        i_lookup_valid  = 1'b0;
        i_lookup_we     = 1'b0;
        i_lookup_dc_hit = 1'b0;
    endtask

    // Drives one lookup in the current cycle and updates the model by the queue rules
    task automatic drive_lookup(input logic [31:0] addr, input mhq_op_e op, input logic dc,
                                input logic exp_replay);
        logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] line;
        logic [31:0] data;
        logic hit;
        logic retry;
        logic upd;
        int slot;
        int off;
        int nb;
        line  = addr[31:4];
        off   = addr[3:0];
        hit   = 1'b0;
        slot  = mtail;
        for (int s = 0; s < `MHQ_DEPTH; s++) begin
            if (mv[s] && ml[s] == line) begin
                hit  = 1'b1;
                slot = s;
            end
        end
        retry = (mcount == `MHQ_DEPTH) && !hit;
        upd   = !dc && op != MHQ_OP_FILL && !retry && !exp_replay;
        nb    = (op == MHQ_OP_SB) ? 1 : (op == MHQ_OP_SH) ? 2 : (op == MHQ_OP_SW) ? 4 : 0;
        data  = rand_bits(32);
        i_lookup_valid  = 1'b1;
        i_lookup_we     = (nb != 0);
        i_lookup_dc_hit = dc;
        i_lookup_addr   = addr;
        i_lookup_op     = op;
        i_lookup_data   = data;
        #1;
        chk("o_lookup_allocating", o_lookup_allocating, upd && !hit);
        if (upd) begin
            if (!hit) begin
                mv[slot] = 1'b1;
                ml[slot] = line;
                mm[slot] = '0;
                mcount++;
                allocs++;
                mtail = (mtail + 1) % `MHQ_DEPTH;
            end
            // Bytes past the end of the line are lost
            for (int k = 0; k < nb; k++) begin
                if (off + k < `MHQ_LINE_SIZE) begin
                    md[slot][(off+k)*8 +: 8] = data[k*8 +: 8];
                    mm[slot][off+k] = 1'b1;
                end
            end
        end
        pend    = 1'b1;
        pupd    = upd;
        ptag    = slot;
        pretry  = retry;
        preplay = exp_replay;
        pfull   = (mcount == `MHQ_DEPTH);
    endtask

    // Moves to the next cycle and drives one lookup in it
    task automatic lookup_next(input logic [31:0] addr, input mhq_op_e op, input logic dc,
                               input logic exp_replay);
        tick();
        drive_lookup(addr, op, dc, exp_replay);
    endtask

    // Answers the head request and checks the merged fill two cycles after done,
    // optionally looking up the head line in the done cycle or the one after
    task automatic ccu_fill(input logic lk_d, input logic lk_d1);
        logic [127:0] line_data;
        logic [127:0] exp;
        logic [`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH] exp_line;
        int n;
        tick();
        drive_idle();
        n = 1;
        while (!o_ccu_req && n < 50) begin
            tick();
            drive_idle();
            n++;
        end
        if (!o_ccu_req) begin
            errors++;
            $display("timeout: o_ccu_req never rose for a queued line");
            return;
        end
        chk("o_ccu_addr", o_ccu_addr, ml[mhead]);
        tick();
        line_data  = rand_bits(`MHQ_LINE_WIDTH);
        i_ccu_done = 1'b1;
        i_ccu_data = line_data;
        for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
            exp[b*8 +: 8] = mm[mhead][b] ? md[mhead][b*8 +: 8] : line_data[b*8 +: 8];
        end
        exp_line  = ml[mhead];
        mv[mhead] = 1'b0;
        mhead     = (mhead + 1) % `MHQ_DEPTH;
        mcount--;
        if (lk_d) drive_lookup({exp_line, 4'h4}, MHQ_OP_LW, 1'b0, 1'b1);
        else drive_idle();
        tick();
        i_ccu_done = 1'b0;
        chk("o_fill_valid", o_fill_valid, 1'b0);
        chk("o_ccu_req", o_ccu_req, 1'b0);
        if (lk_d1) drive_lookup({exp_line, 4'h8}, MHQ_OP_SB, 1'b0, 1'b1);
        else drive_idle();
        tick();
        drive_idle();
        chk("o_fill_valid", o_fill_valid, 1'b1);
        chk("o_fill_addr", o_fill_addr, exp_line);
        chk("o_fill_data", o_fill_data, exp);
        tick();
        chk("o_fill_valid", o_fill_valid, 1'b0);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != start_err) failed++;
        $display("test %0d %s: %s", tests, name, (errors == start_err) ? "pass" : "fail");
        start_err = errors;
    endtask

    initial begin
        lfsr      = 16'd4609;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        failed    = 0;
        start_err = 0;
        mhead     = 0;
        mtail     = 0;
        mcount    = 0;
        allocs    = 0;
        fills     = 0;
        reqs      = 0;
        pend      = 1'b0;
        pupd      = 1'b0;
        pretry    = 1'b0;
        preplay   = 1'b0;
        pfull     = 1'b0;
        ptag      = 0;
        for (int s = 0; s < `MHQ_DEPTH; s++) begin
            mv[s] = 1'b0;
            ml[s] = '0;
            md[s] = '0;
            mm[s] = '0;
        end
        i_rst_n = 1'b0;
        i_lookup_addr = '0;
        i_lookup_op   = '0;
        i_lookup_data = '0;
        i_ccu_done    = 1'b0;
        i_ccu_data    = '0;
        drive_idle();
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;

        tick();
        chk("o_ccu_req", o_ccu_req, 1'b0);
        chk("o_fill_valid", o_fill_valid, 1'b0);
        chk("o_lookup_retry", o_lookup_retry, 1'b0);
        chk("o_lookup_replay", o_lookup_replay, 1'b0);
        chk("o_lookup_allocating", o_lookup_allocating, 1'b0);
        chk("o_mhq_full", o_mhq_full, 1'b0);
        end_test("reset state");

        // Word store at offset 14 keeps only its two low bytes
        lookup_next(32'h0000_1002, MHQ_OP_SH, 1'b0, 1'b0);
        lookup_next(32'h0000_100e, MHQ_OP_SW, 1'b0, 1'b0);
        ccu_fill(1'b0, 1'b0);
        end_test("store miss and fill");

        // Second store lands while the first is still being written
        lookup_next(32'h0000_2001, MHQ_OP_SB, 1'b0, 1'b0);
        lookup_next(32'h0000_2006, MHQ_OP_SH, 1'b0, 1'b0);
        tick();
        drive_idle();
        lookup_next(32'h0000_200c, MHQ_OP_SW, 1'b0, 1'b0);
        ccu_fill(1'b0, 1'b0);
        end_test("store merge and bypass");

        for (int i = 0; i < 4; i++) begin
            lookup_next(32'h0000_3000 + i * 32'h10 + 3, MHQ_OP_SB, 1'b0, 1'b0);
        end
        lookup_next(32'h0000_3f00, MHQ_OP_SW, 1'b0, 1'b0);
        lookup_next(32'h0000_3025, MHQ_OP_LB, 1'b0, 1'b0);
        lookup_next(32'h0000_3012, MHQ_OP_SH, 1'b0, 1'b0);
        repeat (4) ccu_fill(1'b0, 1'b0);
        end_test("full and retry");

        lookup_next(32'h0000_4004, MHQ_OP_SW, 1'b0, 1'b0);
        ccu_fill(1'b1, 1'b0);
        lookup_next(32'h0000_5008, MHQ_OP_SB, 1'b0, 1'b0);
        ccu_fill(1'b0, 1'b1);
        end_test("fill conflict replay");

        lookup_next(32'h0000_6000, MHQ_OP_SW, 1'b1, 1'b0);
        lookup_next(32'h0000_7000, MHQ_OP_FILL, 1'b0, 1'b0);
        repeat (10) begin
            tick();
            drive_idle();
            chk("o_ccu_req", o_ccu_req, 1'b0);
        end
        chk("o_fill_valid pulses", fills, allocs);
        chk("o_ccu_req rises", reqs, allocs);
        end_test("no allocation on hit or fill op");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mhq.f
+incdir+verilog
verilog/mhq_pkg.sv
verilog/mhq_update_if.sv
verilog/mhq_lookup.sv
verilog/mhq_entries.sv
verilog/mhq_fill.sv
verilog/mhq_top.sv
test/mhq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MHQ simulation with Verilator, fail if the log reports failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f mhq.f --top-module mhq_tb \
    -o mhq_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/mhq_sim > sim.log 2>&1 || echo "simulator returned an error"
grep -q "TEST OK" sim.log || { echo "no pass line in sim.log"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } || echo "simulation passed"
